// File: exec_pkg.sv
`default_nettype none

package exec_pkg;

   localparam int xlen = 32;
   localparam int mul_latency = 2;
   localparam int div_steps = 32;

   // rv32im operation codes, grouped by format
   typedef enum logic [5:0] {
      op_nop    = 6'h00,
      op_lui    = 6'h01, op_auipc  = 6'h02, op_jal    = 6'h03, op_jalr   = 6'h04,
      op_beq    = 6'h05, op_bne    = 6'h06, op_blt    = 6'h07, op_bge    = 6'h08,
      op_bltu   = 6'h09, op_bgeu   = 6'h0a,
      op_lb     = 6'h0b, op_lh     = 6'h0c, op_lw     = 6'h0d, op_lbu    = 6'h0e,
      op_lhu    = 6'h0f, op_sb     = 6'h10, op_sh     = 6'h11, op_sw     = 6'h12,
      op_addi   = 6'h13, op_slti   = 6'h14, op_sltiu  = 6'h15, op_xori   = 6'h16,
      op_ori    = 6'h17, op_andi   = 6'h18, op_slli   = 6'h19, op_srli   = 6'h1a,
      op_srai   = 6'h1b,
      op_add    = 6'h1c, op_sub    = 6'h1d, op_sll    = 6'h1e, op_slt    = 6'h1f,
      op_sltu   = 6'h20, op_xor    = 6'h21, op_srl    = 6'h22, op_sra    = 6'h23,
      op_or     = 6'h24, op_and    = 6'h25,
      op_mul    = 6'h26, op_mulh   = 6'h27, op_mulhsu = 6'h28, op_mulhu  = 6'h29,
      op_div    = 6'h2a, op_divu   = 6'h2b, op_rem    = 6'h2c, op_remu   = 6'h2d
   } exec_op_e;

   typedef struct packed {
      exec_op_e          op;
      logic [4:0]        rs1;
      logic [4:0]        rs2;
      logic [xlen-1:0]   imm;
      logic [xlen-1:0]   pc;
   } exec_instr_t;

   // values read from the register file
   typedef struct packed {
      logic [xlen-1:0]   rs1;
      logic [xlen-1:0]   rs2;
   } reg_pair_t;

   typedef struct packed {
      logic              enabled;
      logic [4:0]        key;
      logic [xlen-1:0]   value;
   } fwd_t;

   typedef struct packed {
      logic [xlen-1:0]   a;
      logic [xlen-1:0]   b;
   } operands_t;

   function automatic logic is_mul(input exec_op_e op);
      return op inside {op_mul, op_mulh, op_mulhsu, op_mulhu};
   endfunction

   function automatic logic is_div(input exec_op_e op);
      return op inside {op_div, op_divu, op_rem, op_remu};
   endfunction

   function automatic logic is_unsigned_div(input exec_op_e op);
      return op inside {op_divu, op_remu};
   endfunction

endpackage

`default_nettype wire

// File: operand_forward.sv
`timescale 1ns/100ps
`default_nettype none

module operand_forward (
   input  exec_pkg::exec_instr_t instr,
   input  exec_pkg::reg_pair_t   regs,
   input  exec_pkg::fwd_t        fwd,
   output exec_pkg::operands_t   operands
);

   logic fwd_live;
   logic hit_rs1;
   logic hit_rs2;

   // x0 is hardwired to zero, never take a forwarded write to it
   assign fwd_live = fwd.enabled && (fwd.key != 5'd0);

   assign hit_rs1 = fwd_live && (fwd.key == instr.rs1);
   assign hit_rs2 = fwd_live && (fwd.key == instr.rs2);

   assign operands.a = hit_rs1 ? fwd.value : regs.rs1;
   assign operands.b = hit_rs2 ? fwd.value : regs.rs2;

endmodule

`default_nettype wire

// File: int_alu.sv
`timescale 1ns/100ps
`default_nettype none

module int_alu (
   input  exec_pkg::exec_instr_t        instr,
   input  exec_pkg::operands_t          operands,
   output logic [exec_pkg::xlen-1:0]    alu_result
);

   logic [exec_pkg::xlen-1:0] a;
   logic [exec_pkg::xlen-1:0] b;
   logic [exec_pkg::xlen-1:0] imm;
   logic [exec_pkg::xlen-1:0] mem_addr;
   logic [4:0]                shamt_i;
   logic [4:0]                shamt_r;

   assign a   = operands.a;
   assign b   = operands.b;
   assign imm = instr.imm;

   // loads and stores share the address sum
   assign mem_addr = a + imm;

   assign shamt_i = imm[4:0];
   assign shamt_r = b[4:0];

   always_comb begin
      alu_result = '0;
      case (instr.op)
         exec_pkg::op_lui:   alu_result = imm;
         exec_pkg::op_auipc: alu_result = instr.pc + imm;
         exec_pkg::op_jal,
         exec_pkg::op_jalr:  alu_result = instr.pc + 32'd4;

         // branch compares give 1/0
         exec_pkg::op_beq:   alu_result = {31'd0, a == b};
         exec_pkg::op_bne:   alu_result = {31'd0, a != b};
         exec_pkg::op_blt:   alu_result = {31'd0, $signed(a) < $signed(b)};
         exec_pkg::op_bge:   alu_result = {31'd0, $signed(a) >= $signed(b)};
         exec_pkg::op_bltu:  alu_result = {31'd0, a < b};
         exec_pkg::op_bgeu:  alu_result = {31'd0, a >= b};

         exec_pkg::op_lb,
         exec_pkg::op_lh,
         exec_pkg::op_lw,
         exec_pkg::op_lbu,
         exec_pkg::op_lhu,
         exec_pkg::op_sb,
         exec_pkg::op_sh,
         exec_pkg::op_sw:    alu_result = mem_addr;

         exec_pkg::op_addi:  alu_result = a + imm;
         exec_pkg::op_slti:  alu_result = {31'd0, $signed(a) < $signed(imm)};
         exec_pkg::op_sltiu: alu_result = {31'd0, a < imm};
         exec_pkg::op_xori:  alu_result = a ^ imm;
         exec_pkg::op_ori:   alu_result = a | imm;
         exec_pkg::op_andi:  alu_result = a & imm;
         exec_pkg::op_slli:  alu_result = a << shamt_i;
         exec_pkg::op_srli:  alu_result = a >> shamt_i;
         exec_pkg::op_srai:  alu_result = $signed(a) >>> shamt_i;

         exec_pkg::op_add:   alu_result = a + b;
         exec_pkg::op_sub:   alu_result = a - b;
         exec_pkg::op_sll:   alu_result = a << shamt_r;
         exec_pkg::op_slt:   alu_result = {31'd0, $signed(a) < $signed(b)};
         exec_pkg::op_sltu:  alu_result = {31'd0, a < b};
         exec_pkg::op_xor:   alu_result = a ^ b;
         exec_pkg::op_srl:   alu_result = a >> shamt_r;
         exec_pkg::op_sra:   alu_result = $signed(a) >>> shamt_r;
         exec_pkg::op_or:    alu_result = a | b;
         exec_pkg::op_and:   alu_result = a & b;
         default:            alu_result = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: mul_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mul_unit (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         start,
   input  exec_pkg::exec_op_e           op,
   input  exec_pkg::operands_t          operands,
   output logic                         mul_done,
   output logic [exec_pkg::xlen-1:0]    mul_result
);

   logic               a_signed;
   logic               b_signed;
   logic signed [32:0] a_ext;
   logic signed [32:0] b_ext;
   logic signed [65:0] product;
   logic [63:0]        prod_q;
   logic               hi_sel_q;
   logic               valid_q;

   // mulhu zero-extends both, mulhsu only rs2
   assign a_signed = (op != exec_pkg::op_mulhu);
   assign b_signed = (op == exec_pkg::op_mul) || (op == exec_pkg::op_mulh);

   assign a_ext   = {a_signed & operands.a[31], operands.a};
   assign b_ext   = {b_signed & operands.b[31], operands.b};
   assign product = a_ext * b_ext;

   // stage one
   always_ff @(posedge clk) begin
      prod_q   <= product[63:0];
      hi_sel_q <= (op != exec_pkg::op_mul);
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= start;
      end
   end

   // stage two word select
   assign mul_result = hi_sel_q ? prod_q[63:32] : prod_q[31:0];
   assign mul_done   = valid_q;

   a_mul_latency: assert property (@(posedge clk) disable iff (rstn)
      start |-> ##(exec_pkg::mul_latency - 1) mul_done ##1 !mul_done)
      else $error("multiplier done not a single pulse after start");

endmodule

`default_nettype wire

// File: div_unit.sv
`timescale 1ns/100ps
`default_nettype none

module div_unit (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         start,
   input  exec_pkg::exec_op_e           op,
   input  exec_pkg::operands_t          operands,
   output logic                         div_done,
   output logic [exec_pkg::xlen-1:0]    div_result
);

   logic                      is_signed;
   logic                      rem_op;
   logic                      by_zero;
   logic                      overflow;
   logic [exec_pkg::xlen-1:0] a_abs;
   logic [exec_pkg::xlen-1:0] b_abs;
   logic [32:0]               trial;
   logic [32:0]               diff;

   logic                      running_q;
   logic                      done_q;
   logic [5:0]                count_q;
   logic [exec_pkg::xlen-1:0] rem_q;
   logic [exec_pkg::xlen-1:0] quo_q;
   logic [exec_pkg::xlen-1:0] divisor_q;
   logic                      q_neg_q;
   logic                      r_neg_q;
   logic                      rem_sel_q;
   logic                      special_q;
   logic [exec_pkg::xlen-1:0] special_val_q;
   logic [exec_pkg::xlen-1:0] quo_fix;
   logic [exec_pkg::xlen-1:0] rem_fix;

   assign is_signed = !exec_pkg::is_unsigned_div(op);
   assign rem_op    = (op == exec_pkg::op_rem) || (op == exec_pkg::op_remu);
   assign by_zero   = (operands.b == '0);
   assign overflow  = is_signed && (operands.a == 32'h8000_0000) && (operands.b == '1);

   assign a_abs = (is_signed && operands.a[31]) ? -operands.a : operands.a;
   assign b_abs = (is_signed && operands.b[31]) ? -operands.b : operands.b;

   // restoring step: shift in next dividend bit, try subtract
   assign trial = {rem_q, quo_q[31]};
   assign diff  = trial - {1'b0, divisor_q};

   always_ff @(posedge clk) begin
      if (rstn) begin
         running_q <= 1'b0;
         done_q    <= 1'b0;
         count_q   <= '0;
      end else begin
         done_q <= 1'b0;
         if (start) begin
            running_q <= 1'b1;
            count_q   <= 6'(exec_pkg::div_steps);
         end else if (running_q) begin
            count_q <= count_q - 6'd1;
            if (count_q == 6'd1) begin
               running_q <= 1'b0;
               done_q    <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         rem_q     <= '0;
         quo_q     <= a_abs;
         divisor_q <= b_abs;
         q_neg_q   <= is_signed && (operands.a[31] ^ operands.b[31]);
         r_neg_q   <= is_signed && operands.a[31];
         rem_sel_q <= rem_op;
         special_q <= by_zero || overflow;
         if (by_zero) begin
            special_val_q <= rem_op ? operands.a : '1;
         end else begin
            special_val_q <= rem_op ? '0 : operands.a;
         end
      end else if (running_q) begin
         if (!diff[32]) begin
            rem_q <= diff[31:0];
            quo_q <= {quo_q[30:0], 1'b1};
         end else begin
            rem_q <= trial[31:0];
            quo_q <= {quo_q[30:0], 1'b0};
         end
      end
   end

   assign quo_fix = q_neg_q ? -quo_q : quo_q;
   assign rem_fix = r_neg_q ? -rem_q : rem_q;

   assign div_result = special_q ? special_val_q : (rem_sel_q ? rem_fix : quo_fix);
   assign div_done   = done_q;

   a_no_restart: assert property (@(posedge clk) disable iff (rstn)
      start |-> !running_q)
      else $error("divider started while running");

endmodule

`default_nettype wire

// File: exec_control.sv
`timescale 1ns/100ps
`default_nettype none

module exec_control (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         enabled,
   input  exec_pkg::exec_op_e           op,
   input  logic [exec_pkg::xlen-1:0]    alu_result,
   input  logic [exec_pkg::xlen-1:0]    mul_result,
   input  logic [exec_pkg::xlen-1:0]    div_result,
   input  logic                         mul_done,
   input  logic                         div_done,
   output logic                         mul_start,
   output logic                         div_start,
   output logic                         busy,
   output logic                         completed,
   output logic [exec_pkg::xlen-1:0]    result
);

   typedef enum logic [1:0] {
      st_idle,
      st_mul_wait,
      st_div_wait
   } state_e;

   state_e state;
   logic   issue;
   logic   issue_mul;
   logic   issue_div;

   assign busy  = (state != st_idle);
   assign issue = enabled && !busy;

   assign issue_mul = issue && exec_pkg::is_mul(op);
   assign issue_div = issue && exec_pkg::is_div(op);

   assign mul_start = issue_mul;
   assign div_start = issue_div;

   always_ff @(posedge clk) begin
      if (rstn) begin
         state     <= st_idle;
         completed <= 1'b0;
         result    <= '0;
      end else begin
         completed <= 1'b0;
         case (state)
            st_idle: begin
               if (issue_mul) begin
                  state <= st_mul_wait;
               end else if (issue_div) begin
                  state <= st_div_wait;
               end else if (issue) begin
                  // integer ops finish here
                  result    <= alu_result;
                  completed <= 1'b1;
               end
            end
            st_mul_wait: begin
               if (mul_done) begin
                  result    <= mul_result;
                  completed <= 1'b1;
                  state     <= st_idle;
               end
            end
            st_div_wait: begin
               if (div_done) begin
                  result    <= div_result;
                  completed <= 1'b1;
                  state     <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   a_no_stray_completion: assert property (@(posedge clk) disable iff (rstn)
      (state == st_idle) |-> !(mul_done || div_done))
      else $error("unit finished with no operation outstanding");

   a_enabled_while_busy: assert property (@(posedge clk) disable iff (rstn)
      busy |-> !enabled)
      else $error("enabled raised while busy");

endmodule

`default_nettype wire

// File: exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         enabled,
   input  exec_pkg::exec_instr_t        instr,
   input  exec_pkg::reg_pair_t          regs,
   input  exec_pkg::fwd_t               fwd,
   output logic                         busy,
   output logic                         completed,
   output logic [exec_pkg::xlen-1:0]    result
);

   exec_pkg::operands_t       operands;
   logic [exec_pkg::xlen-1:0] alu_result;
   logic [exec_pkg::xlen-1:0] mul_result;
   logic [exec_pkg::xlen-1:0] div_result;
   logic                      mul_start;
   logic                      mul_done;
   logic                      div_start;
   logic                      div_done;

   operand_forward u_forward (
      .instr    (instr),
      .regs     (regs),
      .fwd      (fwd),
      .operands (operands)
   );

   int_alu u_alu (
      .instr      (instr),
      .operands   (operands),
      .alu_result (alu_result)
   );

   mul_unit u_mul (
      .clk        (clk),
      .rstn       (rstn),
      .start      (mul_start),
      .op         (instr.op),
      .operands   (operands),
      .mul_done   (mul_done),
      .mul_result (mul_result)
   );

   div_unit u_div (
      .clk        (clk),
      .rstn       (rstn),
      .start      (div_start),
      .op         (instr.op),
      .operands   (operands),
      .div_done   (div_done),
      .div_result (div_result)
   );

   exec_control u_control (
      .clk        (clk),
      .rstn       (rstn),
      .enabled    (enabled),
      .op         (instr.op),
      .alu_result (alu_result),
      .mul_result (mul_result),
      .div_result (div_result),
      .mul_done   (mul_done),
      .div_done   (div_done),
      .mul_start  (mul_start),
      .div_start  (div_start),
      .busy       (busy),
      .completed  (completed),
      .result     (result)
   );

endmodule

`default_nettype wire

// File: exec_checker.sv
`timescale 1ns/100ps
`default_nettype none

module exec_checker (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         enabled,
   input  logic                         busy,
   input  logic                         completed,
   input  logic [exec_pkg::xlen-1:0]    result,
   output int                           pass_count,
   output int                           fail_count
);

   logic [31:0] exp_q[$];
   int          lat_q[$];
   int          issue_q[$];
   int          cycle;
   int          test_no;
   logic        started;

   // called by the driver once per applied test
   task automatic expect_result(input logic [31:0] value, input int latency);
      exp_q.push_back(value);
      lat_q.push_back(latency);
   endtask

   initial begin
      pass_count = 0;
      fail_count = 0;
      cycle      = 0;
      test_no    = 0;
      started    = 1'b0;
   end

   // issue edges, counted in clock cycles
   always @(posedge clk) begin
      if (!rstn && enabled && !busy) begin
         issue_q.push_back(cycle);
         started = 1'b1;
      end
      cycle = cycle + 1;
   end

   always @(negedge clk) begin : compare
      logic [31:0] want;
      int          want_lat;
      int          got_lat;
      if (!rstn && !started && (completed || busy || result != '0)) begin
         $display("outputs not idle after reset at time %0t", $time);
         fail_count++;
      end
      if (!rstn && completed) begin
         if (exp_q.size() == 0 || issue_q.size() == 0) begin
            $display("unexpected completion at time %0t with result %h", $time, result);
            fail_count++;
         end else begin
            want     = exp_q.pop_front();
            want_lat = lat_q.pop_front();
            got_lat  = cycle - issue_q.pop_front();
            if (result !== want) begin
               $display("Fail at %0t: test %0d got %h expected %h",
                        $time, test_no, result, want);
               fail_count++;
            end else if (got_lat != want_lat) begin
               $display("test %0d completed %0d cycles after issue instead of %0d",
                        test_no, got_lat, want_lat);
               fail_count++;
            end else begin
               $display("test %0d passed, result %h", test_no, result);
               pass_count++;
            end
            test_no++;
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_exec_unit;

   localparam int pat_cols = 11;
   localparam int max_pats = 64;

   logic                      clk;
   logic                      rstn;
   logic                      enabled;
   exec_pkg::exec_instr_t     instr;
   exec_pkg::reg_pair_t       regs;
   exec_pkg::fwd_t            fwd;
   logic                      busy;
   logic                      completed;
   logic [exec_pkg::xlen-1:0] result;
   int                        pass_count;
   int                        fail_count;

   logic [31:0] pat_mem [0:pat_cols*max_pats-1];
   int          n_pats;
   int          cycle_count;
   int          cycle_limit;

   exec_unit dut (
      .clk       (clk),
      .rstn      (rstn),
      .enabled   (enabled),
      .instr     (instr),
      .regs      (regs),
      .fwd       (fwd),
      .busy      (busy),
      .completed (completed),
      .result    (result)
   );

   exec_checker u_checker (
      .clk        (clk),
      .rstn       (rstn),
      .enabled    (enabled),
      .busy       (busy),
      .completed  (completed),
      .result     (result),
      .pass_count (pass_count),
      .fail_count (fail_count)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] field(input int idx, input int col);
      return pat_mem[idx*pat_cols + col];
   endfunction

   function automatic exec_pkg::exec_op_e op_of(input int idx);
      logic [31:0] word;
      word = field(idx, 0);
      return exec_pkg::exec_op_e'(word[5:0]);
   endfunction

   // cycles from the sampling edge to completed, div is load + 32 steps + register
   function automatic int latency_of(input exec_pkg::exec_op_e op);
      case (op)
         exec_pkg::op_mul, exec_pkg::op_mulh,
         exec_pkg::op_mulhsu, exec_pkg::op_mulhu: return 2;
         exec_pkg::op_div, exec_pkg::op_divu,
         exec_pkg::op_rem, exec_pkg::op_remu:     return 34;
         default:                                 return 1;
      endcase
   endfunction

   task automatic apply_pattern(input int idx);
      logic [31:0] fwd_en;
      fwd_en      = field(idx, 7);
      instr.op    = op_of(idx);
      instr.rs1   = 5'(field(idx, 1));
      instr.rs2   = 5'(field(idx, 2));
      instr.imm   = field(idx, 3);
      instr.pc    = field(idx, 4);
      regs.rs1    = field(idx, 5);
      regs.rs2    = field(idx, 6);
      fwd.enabled = fwd_en[0];
      fwd.key     = 5'(field(idx, 8));
      fwd.value   = field(idx, 9);
      enabled     = 1'b1;
      u_checker.expect_result(field(idx, 10), latency_of(op_of(idx)));
   endtask

   task automatic run_patterns();
      logic back_to_back;
      for (int i = 0; i < n_pats; i++) begin
         apply_pattern(i);
         @(negedge clk);
         back_to_back = (i + 1 < n_pats) && (latency_of(op_of(i)) == 1)
                        && (latency_of(op_of(i + 1)) == 1);
         if (!back_to_back) begin
            enabled = 1'b0;
            while (!completed) @(negedge clk);
         end
      end
      enabled = 1'b0;
   endtask

   initial begin : watchdog
      cycle_count = 0;
      while (cycle_count <= cycle_limit) begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      $display("timeout after %0d cycles with %0d of %0d tests done",
               cycle_count, pass_count + fail_count, n_pats);
      $display("Testbench failed");
      $finish;
   end

   initial begin : main
      rstn    = 1'b1;
      enabled = 1'b0;
      instr   = '0;
      regs    = '0;
      fwd     = '0;
      // unused words keep an out-of-range op
      for (int k = 0; k < pat_cols*max_pats; k++) begin
         pat_mem[k] = ~32'(k);
      end
      $readmemh("exec_patterns.txt", pat_mem);
      n_pats = 0;
      while (n_pats < max_pats && field(n_pats, 0) <= 32'h3f) begin
         n_pats++;
      end
      cycle_limit = 40 * n_pats + 100;

      repeat (2) @(posedge clk);
      @(negedge clk);
      rstn = 1'b0;
      repeat (3) @(negedge clk);

      run_patterns();
      repeat (4) @(negedge clk);

      $display("%0d of %0d tests passed, %0d failed", pass_count, n_pats, fail_count);
      if (n_pats > 0 && pass_count == n_pats && fail_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: exec_patterns.txt
// op rs1 rs2 imm pc reg_rs1 reg_rs2 fwd_en fwd_key fwd_value expected
// all columns hex, one test per line
02 00 00 00001000 00000400 00000000 00000000 0 00 00000000 00001400
03 00 00 00000000 00000ffc 00000000 00000000 0 00 00000000 00001000
1f 01 02 00000000 00000000 ffffffff 00000001 0 00 00000000 00000001
20 01 02 00000000 00000000 ffffffff 00000001 0 00 00000000 00000000
1b 01 00 00000404 00000000 80000000 00000000 0 00 00000000 f8000000
23 01 02 00000000 00000000 f0000000 00000024 0 00 00000000 ff000000
09 01 02 00000000 00000000 00000001 fffffffe 0 00 00000000 00000001
0d 01 00 fffffffc 00000000 00001000 00000000 0 00 00000000 00000ffc
1c 03 04 00000000 00000000 00000010 00000020 1 03 00000100 00000120
1c 05 05 00000000 00000000 00000001 00000002 1 05 00000007 0000000e
1c 00 06 00000000 00000000 00000011 00000022 1 00 12345678 00000033
21 07 08 00000000 00000000 0000ff00 00ff0000 0 07 ffffffff 00ffff00
1d 09 0a 00000000 00000000 00000100 00000001 1 0a 00000010 000000f0
26 01 02 00000000 00000000 fffffffd 00000007 0 00 00000000 ffffffeb
27 01 02 00000000 00000000 80000000 80000000 0 00 00000000 40000000
18 01 00 00000ff0 00000000 12345678 00000000 0 00 00000000 00000670
28 01 02 00000000 00000000 ffffffff ffffffff 0 00 00000000 ffffffff
29 01 02 00000000 00000000 ffffffff ffffffff 0 00 00000000 fffffffe
2a 01 02 00000000 00000000 ffffffec 00000006 0 00 00000000 fffffffd
2c 01 02 00000000 00000000 ffffffec 00000006 0 00 00000000 fffffffe
2b 01 02 00000000 00000000 ffffffec 00000006 0 00 00000000 2aaaaaa7
2d 01 02 00000000 00000000 ffffffec 00000006 0 00 00000000 00000002
2a 01 02 00000000 00000000 00000007 fffffffe 0 00 00000000 fffffffd
2a 01 02 00000000 00000000 00000005 00000000 0 00 00000000 ffffffff
2c 01 02 00000000 00000000 fffffffb 00000000 0 00 00000000 fffffffb
2a 01 02 00000000 00000000 80000000 ffffffff 0 00 00000000 80000000
2c 01 02 00000000 00000000 80000000 ffffffff 0 00 00000000 00000000
13 01 00 00000001 00000000 00000001 00000000 0 00 00000000 00000002

// File: files.f
exec_pkg.sv
operand_forward.sv
int_alu.sv
mul_unit.sv
div_unit.sv
exec_control.sv
exec_unit.sv
exec_checker.sv
tb_exec_unit.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - exec_pkg.sv
  - operand_forward.sv
  - int_alu.sv
  - mul_unit.sv
  - div_unit.sv
  - exec_control.sv
  - exec_unit.sv
  - target: test
    files:
      - exec_checker.sv
      - tb_exec_unit.sv
